//--- design/ex_pkg.sv
`default_nettype none

package ex_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        DIV_DIV,
        DIV_MOD,
        DIV_DIVU,
        DIV_MODU
    } div_op_t;

    typedef enum logic [1:0] {
        ST_NONE,
        ST_BYTE,
        ST_HALF,
        ST_WORD
    } store_kind_t;

    // Decode to execute.
    typedef struct packed {
        logic        gr_we;
        logic        res_from_mem;
        logic [2:0]  mem_type;
        alu_op_t     alu_op;
        logic        div_en;
        div_op_t     div_op;
        store_kind_t store_kind;
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] rkd_value;
        logic [4:0]  dest;
        logic [31:0] pc;
        logic [31:0] inst;
        logic        csr_we;
        logic        csr_re;
        logic [13:0] csr_num;
        logic [31:0] csr_wmask;
        logic [31:0] csr_wvalue;
        logic        ertn;
        logic        syscall;
        logic        rdcntvl;
        logic        rdcntvh;
    } ex_in_t;

    // Execute to memory.
    typedef struct packed {
        logic        gr_we;
        logic        res_from_mem;
        logic [2:0]  mem_type;
        logic [1:0]  addr_low2;
        logic [4:0]  dest;
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] result;
        logic        csr_we;
        logic        csr_re;
        logic [13:0] csr_num;
        logic [31:0] csr_wmask;
        logic [31:0] csr_wvalue;
        logic        ertn;
        logic        syscall;
    } ex_out_t;

    // Forwarding back to decode.
    typedef struct packed {
        logic        bypass;
        logic        load_pending;
        logic [4:0]  dest;
        logic [31:0] result;
        logic        div_busy;
        logic        gr_we;
        logic        csr_re;
        logic [13:0] csr_num;
    } ex_fwd_t;

    typedef struct packed {
        logic        en;
        logic [3:0]  we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } sram_wr_t;

endpackage

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  ex_pkg::alu_op_t alu_op,
    input  logic [31:0]     src1,
    input  logic [31:0]     src2,
    output logic [31:0]     result
);

    logic        is_sub;
    logic [31:0] adder_b;
    logic [32:0] adder_out;
    logic        slt_bit;
    logic        sltu_bit;
    logic [4:0]  shamt;

    // Subtract and both compares share the one adder.
    assign is_sub = (alu_op == ex_pkg::ALU_SUB) ||
                    (alu_op == ex_pkg::ALU_SLT) ||
                    (alu_op == ex_pkg::ALU_SLTU);

    assign adder_b   = is_sub ? ~src2 : src2;
    assign adder_out = {1'b0, src1} + {1'b0, adder_b} + {32'd0, is_sub};

    // Signs differ: src1 negative wins. Same sign: look at the difference.
    assign slt_bit  = (src1[31] & ~src2[31]) |
                      (~(src1[31] ^ src2[31]) & adder_out[31]);
    assign sltu_bit = ~adder_out[32]; // No carry out means borrow.

    assign shamt = src2[4:0];

    always_comb begin
        case (alu_op)
            ex_pkg::ALU_ADD,
            ex_pkg::ALU_SUB:  result = adder_out[31:0];
            ex_pkg::ALU_SLT:  result = {31'd0, slt_bit};
            ex_pkg::ALU_SLTU: result = {31'd0, sltu_bit};
            ex_pkg::ALU_AND:  result = src1 & src2;
            ex_pkg::ALU_OR:   result = src1 | src2;
            ex_pkg::ALU_NOR:  result = ~(src1 | src2);
            ex_pkg::ALU_XOR:  result = src1 ^ src2;
            ex_pkg::ALU_SLL:  result = src1 << shamt;
            ex_pkg::ALU_SRL:  result = src1 >> shamt;
            ex_pkg::ALU_SRA:  result = $signed(src1) >>> shamt;
            ex_pkg::ALU_LUI:  result = src2; // Decode already shifted the immediate.
            default:          result = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/divider.sv
`timescale 1ns/1ps
`default_nettype none

module divider #(
    parameter int DIV_WIDTH = 32
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 start,
    input  ex_pkg::div_op_t      op,
    input  logic [DIV_WIDTH-1:0] src1,
    input  logic [DIV_WIDTH-1:0] src2,
    output logic [DIV_WIDTH-1:0] result,
    output logic                 busy,
    output logic                 done
);

    localparam int CNT_W = $clog2(DIV_WIDTH);

    logic [CNT_W-1:0]     cnt;
    logic [DIV_WIDTH-1:0] quot;     // Dividend shifts out, quotient bits shift in.
    logic [DIV_WIDTH-1:0] rem;
    logic [DIV_WIDTH-1:0] divisor;
    logic                 quot_neg;
    logic                 rem_neg;
    logic                 by_zero;
    logic                 want_rem;
    logic                 is_signed;
    logic [DIV_WIDTH-1:0] abs1;
    logic [DIV_WIDTH-1:0] abs2;
    logic [DIV_WIDTH:0]   shifted;
    logic [DIV_WIDTH:0]   trial;
    logic [DIV_WIDTH-1:0] quot_fix;
    logic [DIV_WIDTH-1:0] rem_fix;

    assign is_signed = (op == ex_pkg::DIV_DIV) || (op == ex_pkg::DIV_MOD);
    assign abs1 = (is_signed && src1[DIV_WIDTH-1]) ? -src1 : src1;
    assign abs2 = (is_signed && src2[DIV_WIDTH-1]) ? -src2 : src2;

    assign shifted = {rem, quot[DIV_WIDTH-1]};
    assign trial   = shifted - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(DIV_WIDTH - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // One restoring step per busy cycle.
    always_ff @(posedge clk) begin
        if (start) begin
            quot     <= abs1;
            rem      <= '0;
            divisor  <= abs2;
            quot_neg <= is_signed && (src1[DIV_WIDTH-1] ^ src2[DIV_WIDTH-1]);
            rem_neg  <= is_signed && src1[DIV_WIDTH-1];
            by_zero  <= (src2 == '0);
            want_rem <= (op == ex_pkg::DIV_MOD) || (op == ex_pkg::DIV_MODU);
        end else if (busy) begin
            if (!trial[DIV_WIDTH]) begin
                rem  <= trial[DIV_WIDTH-1:0];
                quot <= {quot[DIV_WIDTH-2:0], 1'b1};
            end else begin
                rem  <= shifted[DIV_WIDTH-1:0];
                quot <= {quot[DIV_WIDTH-2:0], 1'b0};
            end
        end
    end

    // Sign fix. Remainder follows the dividend.
    assign quot_fix = quot_neg ? -quot : quot;
    assign rem_fix  = rem_neg ? -rem : rem;
    assign result   = want_rem ? rem_fix : (by_zero ? '1 : quot_fix);

    assert property (@(posedge clk) disable iff (!resetn) start |-> !busy)
        else $error("divider started while busy");

endmodule

`default_nettype wire

//--- design/store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module store_unit (
    input  logic                valid,
    input  ex_pkg::store_kind_t store_kind,
    input  logic [31:0]         addr,
    input  logic [31:0]         rkd_value,
    input  logic                wb_ex,
    input  logic                mem_ex,
    input  logic                ertn_flush,
    output ex_pkg::sram_wr_t    sram_wr
);

    logic flush;

    assign flush = wb_ex || mem_ex || ertn_flush;

    always_comb begin
        sram_wr.en   = 1'b1;
        sram_wr.addr = {addr[31:2], 2'b00};
        sram_wr.we   = 4'b0000;
        if (valid && !flush) begin
            case (store_kind)
                ex_pkg::ST_BYTE: sram_wr.we = 4'b0001 << addr[1:0];
                ex_pkg::ST_HALF: sram_wr.we = addr[1] ? 4'b1100 : 4'b0011;
                ex_pkg::ST_WORD: sram_wr.we = 4'b1111;
                default:         sram_wr.we = 4'b0000;
            endcase
        end
        // Lanes are replicated, the enables pick the one that lands.
        case (store_kind)
            ex_pkg::ST_BYTE: sram_wr.wdata = {4{rkd_value[7:0]}};
            ex_pkg::ST_HALF: sram_wr.wdata = {2{rkd_value[15:0]}};
            default:         sram_wr.wdata = rkd_value;
        endcase
    end

endmodule

`default_nettype wire

//--- design/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic                clk,
    input  logic                resetn,
    input  logic                in_valid,
    input  ex_pkg::ex_in_t      in_bus,
    output logic                in_allowin,
    output logic                out_valid,
    output ex_pkg::ex_out_t     out_bus,
    input  logic                mem_allowin,
    input  logic                wb_ex,
    output ex_pkg::ex_fwd_t     fwd,
    output ex_pkg::alu_op_t     alu_op,
    output logic [31:0]         src1,
    output logic [31:0]         src2,
    input  logic [31:0]         alu_result,
    output logic                div_start,
    output ex_pkg::div_op_t     div_op,
    input  logic [31:0]         div_result,
    input  logic                div_busy,
    input  logic                div_done,
    output ex_pkg::store_kind_t store_kind,
    output logic [31:0]         rkd_value,
    output logic                valid
);

    ex_pkg::ex_in_t ex_q;
    logic [63:0]    cnt_value;
    logic [63:0]    cnt_snap;   // Counter as seen when the instruction came in.
    logic           div_started;
    logic           div_finished;
    logic           ready_go;
    logic           accept;
    logic [31:0]    final_result;

    assign accept     = in_valid && in_allowin;
    assign ready_go   = !ex_q.div_en || div_finished || (div_started && div_done);
    assign out_valid  = valid && ready_go;
    assign in_allowin = !valid || (out_valid && mem_allowin);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt_value <= 64'd0;
        end else begin
            cnt_value <= cnt_value + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else if (wb_ex) begin
            valid <= 1'b0;
        end else if (in_allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_q     <= in_bus;
            cnt_snap <= cnt_value;
        end
    end

    // Start once per instruction, after any flushed division has drained.
    assign div_start = valid && ex_q.div_en && !div_started && !div_busy;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            div_started  <= 1'b0;
            div_finished <= 1'b0;
        end else if (accept) begin
            div_started  <= 1'b0;
            div_finished <= 1'b0;
        end else begin
            if (div_start) begin
                div_started <= 1'b1;
            end
            if (div_started && div_done) begin
                div_finished <= 1'b1; // Keeps ready_go up under back-pressure.
            end
        end
    end

    assign alu_op     = ex_q.alu_op;
    assign src1       = ex_q.src1;
    assign src2       = ex_q.src2;
    assign div_op     = ex_q.div_op;
    assign store_kind = ex_q.store_kind;
    assign rkd_value  = ex_q.rkd_value;

    assign final_result = ex_q.rdcntvl ? cnt_snap[31:0]  :
                          ex_q.rdcntvh ? cnt_snap[63:32] :
                          ex_q.div_en  ? div_result      : alu_result;

    always_comb begin
        out_bus.gr_we        = ex_q.gr_we;
        out_bus.res_from_mem = ex_q.res_from_mem;
        out_bus.mem_type     = ex_q.mem_type;
        out_bus.addr_low2    = alu_result[1:0];
        out_bus.dest         = ex_q.dest;
        out_bus.pc           = ex_q.pc;
        out_bus.inst         = ex_q.inst;
        out_bus.result       = final_result;
        out_bus.csr_we       = ex_q.csr_we;
        out_bus.csr_re       = ex_q.csr_re;
        out_bus.csr_num      = ex_q.csr_num;
        out_bus.csr_wmask    = ex_q.csr_wmask;
        out_bus.csr_wvalue   = ex_q.csr_wvalue;
        out_bus.ertn         = ex_q.ertn;
        out_bus.syscall      = ex_q.syscall;
    end

    always_comb begin
        fwd.bypass       = valid && ex_q.gr_we;
        fwd.load_pending = valid && ex_q.res_from_mem;
        fwd.dest         = ex_q.dest;
        fwd.result       = final_result;
        fwd.div_busy     = valid && div_busy;
        fwd.gr_we        = ex_q.gr_we;
        fwd.csr_re       = ex_q.csr_re;
        fwd.csr_num      = ex_q.csr_num;
    end

    assert property (@(posedge clk) disable iff (!resetn)
        out_valid && !mem_allowin && !wb_ex |=> $stable(out_bus))
        else $error("out_bus changed while stalled");

endmodule

`default_nettype wire

//--- design/ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module ex_top (
    input  logic             clk,
    input  logic             resetn,
    input  logic             in_valid,
    input  ex_pkg::ex_in_t   in_bus,
    output logic             in_allowin,
    output logic             out_valid,
    output ex_pkg::ex_out_t  out_bus,
    input  logic             mem_allowin,
    input  logic             wb_ex,
    input  logic             mem_ex,
    input  logic             ertn_flush,
    output ex_pkg::ex_fwd_t  fwd,
    output ex_pkg::sram_wr_t sram_wr
);

    ex_pkg::alu_op_t     alu_op;
    ex_pkg::div_op_t     div_op;
    ex_pkg::store_kind_t store_kind;
    logic [31:0]         src1;
    logic [31:0]         src2;
    logic [31:0]         alu_result;
    logic [31:0]         div_result;
    logic [31:0]         rkd_value;
    logic                div_start;
    logic                div_busy;
    logic                div_done;
    logic                valid;

    ex_stage u_stage (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .in_bus     (in_bus),
        .in_allowin (in_allowin),
        .out_valid  (out_valid),
        .out_bus    (out_bus),
        .mem_allowin(mem_allowin),
        .wb_ex      (wb_ex),
        .fwd        (fwd),
        .alu_op     (alu_op),
        .src1       (src1),
        .src2       (src2),
        .alu_result (alu_result),
        .div_start  (div_start),
        .div_op     (div_op),
        .div_result (div_result),
        .div_busy   (div_busy),
        .div_done   (div_done),
        .store_kind (store_kind),
        .rkd_value  (rkd_value),
        .valid      (valid)
    );

    alu u_alu (
        .alu_op(alu_op),
        .src1  (src1),
        .src2  (src2),
        .result(alu_result)
    );

    divider #(
        .DIV_WIDTH(32)
    ) u_div (
        .clk   (clk),
        .resetn(resetn),
        .start (div_start),
        .op    (div_op),
        .src1  (src1),
        .src2  (src2),
        .result(div_result),
        .busy  (div_busy),
        .done  (div_done)
    );

    store_unit u_store (
        .valid     (valid),
        .store_kind(store_kind),
        .addr      (alu_result),
        .rkd_value (rkd_value),
        .wb_ex     (wb_ex),
        .mem_ex    (mem_ex),
        .ertn_flush(ertn_flush),
        .sram_wr   (sram_wr)
    );

endmodule

`default_nettype wire

//--- test/tb_ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_top;

    localparam int WAIT_LIMIT = 100;

    logic             clk;
    logic             resetn;
    logic             in_valid;
    ex_pkg::ex_in_t   in_bus;
    logic             in_allowin;
    logic             out_valid;
    ex_pkg::ex_out_t  out_bus;
    logic             mem_allowin;
    logic             wb_ex;
    logic             mem_ex;
    logic             ertn_flush;
    ex_pkg::ex_fwd_t  fwd;
    ex_pkg::sram_wr_t sram_wr;

    int               seed;
    int               checks;
    int               mismatches;
    int               timeouts;
    logic [63:0]      stable_model;  // Reference stable counter.
    logic [63:0]      accept_count;  // Model count seen by the last accepting edge.
    ex_pkg::ex_out_t  got_out;
    ex_pkg::sram_wr_t got_sram;
    ex_pkg::ex_fwd_t  got_fwd;

    ex_top u_dut (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .in_bus     (in_bus),
        .in_allowin (in_allowin),
        .out_valid  (out_valid),
        .out_bus    (out_bus),
        .mem_allowin(mem_allowin),
        .wb_ex      (wb_ex),
        .mem_ex     (mem_ex),
        .ertn_flush (ertn_flush),
        .fwd        (fwd),
        .sram_wr    (sram_wr)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        if (!resetn) begin
            stable_model <= 64'd0;
        end else begin
            stable_model <= stable_model + 64'd1;
        end
    end

    function automatic logic [31:0] alu_model(ex_pkg::alu_op_t op, logic [31:0] a,
                                              logic [31:0] b);
        case (op)
            ex_pkg::ALU_ADD:  return a + b;
            ex_pkg::ALU_SUB:  return a - b;
            ex_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ex_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ex_pkg::ALU_AND:  return a & b;
            ex_pkg::ALU_OR:   return a | b;
            ex_pkg::ALU_NOR:  return ~(a | b);
            ex_pkg::ALU_XOR:  return a ^ b;
            ex_pkg::ALU_SLL:  return a << b[4:0];
            ex_pkg::ALU_SRL:  return a >> b[4:0];
            ex_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
            ex_pkg::ALU_LUI:  return b;
            default:          return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] div_model(ex_pkg::div_op_t op, logic [31:0] a,
                                              logic [31:0] b);
        logic        sgn;
        logic [31:0] mag_a;
        logic [31:0] mag_b;
        logic [31:0] q;
        logic [31:0] r;
        sgn   = (op == ex_pkg::DIV_DIV) || (op == ex_pkg::DIV_MOD);
        mag_a = (sgn && a[31]) ? -a : a;
        mag_b = (sgn && b[31]) ? -b : b;
        if (b == 32'd0) begin
            q = 32'hffff_ffff;
            r = a;
        end else begin
            q = mag_a / mag_b;
            r = mag_a % mag_b;
            if (sgn && (a[31] ^ b[31])) begin
                q = -q;
            end
            if (sgn && a[31]) begin
                r = -r; // Remainder keeps the dividend's sign.
            end
        end
        return (op == ex_pkg::DIV_MOD || op == ex_pkg::DIV_MODU) ? r : q;
    endfunction

    function automatic ex_pkg::sram_wr_t store_model(ex_pkg::store_kind_t kind,
                                                     logic [31:0] addr, logic [31:0] data,
                                                     logic blocked);
        ex_pkg::sram_wr_t s;
        s.en    = 1'b1;
        s.addr  = addr & 32'hffff_fffc;
        s.we    = 4'b0000;
        s.wdata = data;
        case (kind)
            ex_pkg::ST_BYTE: begin
                s.wdata          = {4{data[7:0]}};
                s.we[addr[1:0]]  = 1'b1;
            end
            ex_pkg::ST_HALF: begin
                s.wdata = {2{data[15:0]}};
                s.we    = addr[1] ? 4'b1100 : 4'b0011;
            end
            ex_pkg::ST_WORD: s.we = 4'b1111;
            default:         s.we = 4'b0000;
        endcase
        if (blocked) begin
            s.we = 4'b0000;
        end
        return s;
    endfunction

    function automatic ex_pkg::ex_out_t expect_out(ex_pkg::ex_in_t b, logic [31:0] res);
        ex_pkg::ex_out_t o;
        logic [31:0]     alu_value;
        alu_value      = alu_model(b.alu_op, b.src1, b.src2);
        o.gr_we        = b.gr_we;
        o.res_from_mem = b.res_from_mem;
        o.mem_type     = b.mem_type;
        o.addr_low2    = alu_value[1:0];
        o.dest         = b.dest;
        o.pc           = b.pc;
        o.inst         = b.inst;
        o.result       = res;
        o.csr_we       = b.csr_we;
        o.csr_re       = b.csr_re;
        o.csr_num      = b.csr_num;
        o.csr_wmask    = b.csr_wmask;
        o.csr_wvalue   = b.csr_wvalue;
        o.ertn         = b.ertn;
        o.syscall      = b.syscall;
        return o;
    endfunction

    function automatic ex_pkg::ex_fwd_t expect_fwd(ex_pkg::ex_in_t b, logic [31:0] res);
        ex_pkg::ex_fwd_t f;
        f.bypass       = b.gr_we;
        f.load_pending = b.res_from_mem;
        f.dest         = b.dest;
        f.result       = res;
        f.div_busy     = 1'b0;
        f.gr_we        = b.gr_we;
        f.csr_re       = b.csr_re;
        f.csr_num      = b.csr_num;
        return f;
    endfunction

    task automatic make_bus(input ex_pkg::alu_op_t op, input logic [31:0] a,
                            input logic [31:0] b, output ex_pkg::ex_in_t bus);
        bus              = '0;
        bus.gr_we        = 1'b1;
        bus.alu_op       = op;
        bus.src1         = a;
        bus.src2         = b;
        bus.rkd_value    = $random(seed);
        bus.dest         = 5'($random(seed));
        bus.pc           = $random(seed);
        bus.inst         = $random(seed);
        bus.mem_type     = 3'($random(seed));
        bus.csr_num      = 14'($random(seed));
        bus.csr_wmask    = $random(seed);
        bus.csr_wvalue   = $random(seed);
        bus.res_from_mem = 1'($random(seed));
        bus.csr_we       = 1'($random(seed));
        bus.csr_re       = 1'($random(seed));
        bus.ertn         = 1'($random(seed));
        bus.syscall      = 1'($random(seed));
    endtask

    task automatic check_out(input ex_pkg::ex_out_t got, input ex_pkg::ex_out_t exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s, out_bus %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_sram(input ex_pkg::sram_wr_t got, input ex_pkg::sram_wr_t exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s, sram_wr %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_fwd(input ex_pkg::ex_fwd_t got, input ex_pkg::ex_fwd_t exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s, fwd %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Starts and ends 1 ns after a rising edge.
    task automatic issue(input ex_pkg::ex_in_t bus);
        int n;
        n        = 0;
        in_bus   = bus;
        in_valid = 1'b1;
        #1;
        while (!in_allowin && n < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!in_allowin) begin
            timeouts++;
            $display("timeout at %0t: the stage never accepted an instruction", $time);
        end else begin
            accept_count = stable_model;
            @(posedge clk);
        end
        #1;
        in_valid = 1'b0;
    endtask

    // Samples the stage while out_valid is up, then lets it advance.
    task automatic collect(input logic div_wait);
        int n;
        n = 0;
        #1;
        while (!out_valid && n < WAIT_LIMIT) begin
            if (div_wait) begin
                check_bit(in_allowin, 1'b0, "in_allowin during division");
                if (n > 0) begin
                    check_bit(fwd.div_busy, 1'b1, "fwd.div_busy during division");
                end
            end
            @(posedge clk);
            #2;
            n++;
        end
        if (!out_valid) begin
            timeouts++;
            $display("timeout at %0t: no result left the stage", $time);
        end
        got_out  = out_bus;
        got_sram = sram_wr;
        got_fwd  = fwd;
        @(posedge clk);
        #1;
    endtask

    task automatic test_reset_state();
        #1;
        check_bit(out_valid, 1'b0, "out_valid after reset");
        check_bit(fwd.div_busy, 1'b0, "fwd.div_busy after reset");
        check_bit(sram_wr.we != 4'b0000, 1'b0, "byte enables after reset");
        @(posedge clk);
        #1;
    endtask

    task automatic test_alu_ops();
        ex_pkg::ex_in_t  bus;
        ex_pkg::alu_op_t op;
        logic [31:0]     res;
        for (int i = 0; i < 12; i++) begin
            for (int k = 0; k < 4; k++) begin
                op = ex_pkg::alu_op_t'(i);
                make_bus(op, $random(seed), $random(seed), bus);
                res = alu_model(op, bus.src1, bus.src2);
                issue(bus);
                collect(1'b0);
                check_out(got_out, expect_out(bus, res), "alu result");
                check_fwd(got_fwd, expect_fwd(bus, res), "alu forward");
            end
        end
    endtask

    task automatic test_division();
        ex_pkg::ex_in_t bus;
        logic [31:0]    a;
        logic [31:0]    b;
        logic [31:0]    res;
        int             num [6] = '{100, -100, 100, -100, 12345, -9};
        int             den [6] = '{7, 7, -7, -7, 0, 0};
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 7; j++) begin
                a = (j < 6) ? num[j] : $random(seed);
                b = (j < 6) ? den[j] : $random(seed);
                make_bus(ex_pkg::ALU_ADD, a, b, bus);
                bus.div_en = 1'b1;
                bus.div_op = ex_pkg::div_op_t'(i);
                res = div_model(bus.div_op, a, b);
                issue(bus);
                collect(1'b1);
                check_out(got_out, expect_out(bus, res), "division result");
            end
        end
    endtask

    task automatic test_stores();
        ex_pkg::ex_in_t bus;
        logic [31:0]    base;
        logic [31:0]    addr;
        for (int kind = 0; kind < 4; kind++) begin
            for (int off = 0; off < 4; off++) begin
                base = $random(seed);
                addr = {base[31:2], 2'(off)};
                make_bus(ex_pkg::ALU_ADD, {base[31:2], 2'b00}, 32'(off), bus);
                bus.store_kind = ex_pkg::store_kind_t'(kind);
                bus.gr_we      = (kind == 0);
                issue(bus);
                collect(1'b0);
                check_sram(got_sram, store_model(bus.store_kind, addr, bus.rkd_value, 1'b0),
                           "store write");
                check_out(got_out, expect_out(bus, addr), "store address");
            end
        end
    endtask

    task automatic test_back_pressure();
        ex_pkg::ex_in_t  first;
        ex_pkg::ex_in_t  second;
        ex_pkg::ex_out_t held;
        make_bus(ex_pkg::ALU_XOR, $random(seed), $random(seed), first);
        make_bus(ex_pkg::ALU_SUB, $random(seed), $random(seed), second);
        mem_allowin = 1'b0;
        issue(first);
        in_bus   = second; // Offered while the stage is stalled.
        in_valid = 1'b1;
        #1;
        held = out_bus;
        check_out(held, expect_out(first, alu_model(first.alu_op, first.src1, first.src2)),
                  "stalled result");
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            #2;
            check_out(out_bus, held, "out_bus under back-pressure");
            check_bit(in_allowin, 1'b0, "in_allowin under back-pressure");
        end
        @(posedge clk);
        #1;
        mem_allowin = 1'b1;
        issue(second);
        collect(1'b0);
        check_out(got_out, expect_out(second, alu_model(second.alu_op, second.src1,
                  second.src2)), "result after release");
    endtask

    task automatic test_flush();
        ex_pkg::ex_in_t bus;
        logic [31:0]    addr;
        make_bus(ex_pkg::ALU_ADD, $random(seed), 32'd0, bus);
        bus.store_kind = ex_pkg::ST_WORD;
        addr = bus.src1;
        mem_allowin = 1'b0; // Held, so only the flush can empty the stage.
        issue(bus);
        wb_ex = 1'b1;
        #1;
        check_sram(sram_wr, store_model(ex_pkg::ST_WORD, addr, bus.rkd_value, 1'b1),
                   "store under wb_ex");
        @(posedge clk);
        #1;
        wb_ex       = 1'b0;
        mem_allowin = 1'b1;
        #1;
        check_bit(out_valid, 1'b0, "out_valid after wb_ex");
        @(posedge clk);
        #1;
        // Memory and ertn flushes block the write but let the instruction go on.
        for (int sel = 0; sel < 2; sel++) begin
            make_bus(ex_pkg::ALU_ADD, $random(seed), 32'd0, bus);
            bus.store_kind = ex_pkg::ST_HALF;
            addr = bus.src1;
            mem_allowin = 1'b0;
            issue(bus);
            mem_ex     = (sel == 0);
            ertn_flush = (sel == 1);
            #1;
            check_sram(sram_wr, store_model(ex_pkg::ST_HALF, addr, bus.rkd_value, 1'b1),
                       sel == 0 ? "store under mem_ex" : "store under ertn_flush");
            @(posedge clk);
            #1;
            mem_ex      = 1'b0;
            ertn_flush  = 1'b0;
            mem_allowin = 1'b1;
            collect(1'b0);
            check_sram(got_sram, store_model(ex_pkg::ST_HALF, addr, bus.rkd_value, 1'b0),
                       "store after flush drops");
        end
    endtask

    task automatic test_counter_fwd();
        ex_pkg::ex_in_t bus;
        logic [63:0]    c1;
        logic [31:0]    r1;
        logic [31:0]    res;
        make_bus(ex_pkg::ALU_ADD, $random(seed), $random(seed), bus);
        bus.rdcntvl = 1'b1;
        issue(bus);
        c1 = accept_count;
        collect(1'b0);
        r1 = got_out.result;
        check_out(got_out, expect_out(bus, c1[31:0]), "first rdcntvl.w");
        issue(bus);
        collect(1'b0);
        check_out(got_out, expect_out(bus, accept_count[31:0]), "second rdcntvl.w");
        checks++;
        if (got_out.result <= r1 || got_out.result - r1 < 32'(accept_count - c1)) begin
            mismatches++;
            $display("mismatch at %0t: counter read %0d then %0d over %0d cycles", $time,
                     r1, got_out.result, accept_count - c1);
        end
        bus.rdcntvl = 1'b0;
        bus.rdcntvh = 1'b1;
        issue(bus);
        collect(1'b0);
        check_out(got_out, expect_out(bus, 32'd0), "rdcntvh.w");
        make_bus(ex_pkg::ALU_OR, $random(seed), $random(seed), bus);
        res = alu_model(ex_pkg::ALU_OR, bus.src1, bus.src2);
        mem_allowin = 1'b0;
        issue(bus);
        #1;
        check_fwd(fwd, expect_fwd(bus, res), "forward of held instruction");
        @(posedge clk);
        #1;
        mem_allowin = 1'b1;
        collect(1'b0);
        check_out(got_out, expect_out(bus, res), "held instruction result");
    endtask

    initial begin
        seed        = 32'h3867;
        checks      = 0;
        mismatches  = 0;
        timeouts    = 0;
        clk         = 1'b0;
        resetn      = 1'b0;
        in_valid    = 1'b0;
        in_bus      = '0;
        mem_allowin = 1'b1;
        wb_ex       = 1'b0;
        mem_ex      = 1'b0;
        ertn_flush  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b1;
        test_reset_state();
        test_alu_ops();
        test_division();
        test_stores();
        test_back_pressure();
        test_flush();
        test_counter_fwd();
        $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
design/ex_pkg.sv
design/alu.sv
design/divider.sv
design/store_unit.sv
design/ex_stage.sv
design/ex_top.sv
test/tb_ex_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the testbench reports success.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_ex_top -f all.f -o sim_ex_top &&
./obj_dir/sim_ex_top | tee /dev/stderr | grep -qx "Verification passed" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
